// ==== source/notePkg.sv ====
// Positions count pixels down from the top of the field and must stay below 1024
`default_nettype none

package notePkg;

    // ----------------------------------------
    // Field geometry and lane count
    // ----------------------------------------
    localparam int LaneCount = 5;                       // Lanes across the field

    typedef logic [9:0]           posT;                 // Vertical note position in pixels
    typedef logic [7:0]           keycodeT;             // Keyboard scan code
    typedef logic [2:0]           laneCodeT;            // Zero means no lane and 1 to 5 pick lanes 0 to 4
    typedef logic [LaneCount-1:0] laneMaskT;            // One bit per lane
    typedef logic [9:0]           staminaT;             // One bit per remaining stamina unit

    // Spawn FSM states
    typedef enum logic {
        spawnArmed,                                     // Waiting for a nonzero spawn code
        spawnFired                                      // Spawn taken and waiting for both codes to clear
    } spawnStateT;

    // ----------------------------------------
    // Motion and scoring constants
    // ----------------------------------------
    localparam posT SpawnY   = 10'd80;                  // Spawn row and parking row of an empty slot
    localparam posT NoteStep = 10'd3;                   // Fall per frame
    localparam posT MissY    = 10'd525;                 // First row past the bottom line

    localparam staminaT StaminaFull = '1;               // Every unit present

    // Lane keys in lane order
    // Any scan code outside this table releases the pressed flags of its input
    localparam keycodeT LaneKey [LaneCount] = '{
        8'h07,
        8'h09,
        8'h2C,
        8'h0D,
        8'h0E
    };

endpackage

`default_nettype wire

// ==== source/spawnDecoder.sv ====
// Codes above 5 are ignored and a held nonzero code spawns only once until both codes return to zero
`default_nettype none
`timescale 1ns/1ps

module spawnDecoder (
    input  logic              Reset,       // Frame clock
    input  logic              frame_clk,   // Asynchronous reset, active high
    input  notePkg::laneCodeT spawnCode0,
    input  notePkg::laneCodeT spawnCode1,
    output notePkg::laneMaskT spawnMask    // One-cycle request per lane
);
    import notePkg::*;

    spawnStateT state;
    spawnStateT stateNext;
    logic       anyCode;                   // Either code is nonzero
    laneMaskT   requested;                 // Lanes named by the two codes

    // Turns one lane code into its lane bit
    function automatic laneMaskT laneBit(input laneCodeT code);
        laneMaskT mask;
        mask = '0;
        if (code != 3'd0 && code <= laneCodeT'(LaneCount))
            mask[code - 3'd1] = 1'b1;      // Code 1 is lane 0
        return mask;
    endfunction

    assign anyCode   = (spawnCode0 != '0) || (spawnCode1 != '0);
    assign requested = laneBit(spawnCode0) | laneBit(spawnCode1); // Equal codes merge into one bit

    // Mask is a pulse that only leaves the armed state
    always_comb begin
        stateNext = state;
        spawnMask = '0;
        case (state)
            spawnArmed: begin
                if (anyCode) begin
                    spawnMask = requested;
                    stateNext = spawnFired;
                end
            end
            spawnFired: begin
                if (!anyCode)
                    stateNext = spawnArmed; // Both codes released so the next one counts
            end
            default: stateNext = spawnArmed;
        endcase
    end

    always_ff @(posedge Reset or posedge frame_clk) begin
        if (frame_clk)
            state <= spawnArmed;
        else
            state <= stateNext;
    end

endmodule

`default_nettype wire

// ==== source/keyDecoder.sv ====
// Each keycode input keeps its own pressed flags and only a non-lane code on that input releases them
`default_nettype none
`timescale 1ns/1ps

module keyDecoder (
    input  logic              Reset,       // Frame clock
    input  logic              frame_clk,   // Asynchronous reset, active high
    input  notePkg::keycodeT  keycode0,
    input  notePkg::keycodeT  keycode1,
    output notePkg::laneMaskT hitMask      // One pulse per new press
);
    import notePkg::*;

    keycodeT  keys    [2];                 // Both keycode inputs side by side
    laneMaskT match   [2];                 // Lanes whose key each input shows
    laneMaskT fresh   [2];                 // Matches not yet seen on that input
    laneMaskT pressed [2];                 // Lanes already taken by each input

    assign keys[0] = keycode0;
    assign keys[1] = keycode1;

    // ----------------------------------------
    // Key lookup
    // ----------------------------------------
    always_comb begin
        for (int k = 0; k < $size(keys); k++) begin
            for (int l = 0; l < LaneCount; l++)
                match[k][l] = (keys[k] == LaneKey[l]);
            fresh[k] = match[k] & ~pressed[k]; // A held key stays quiet
        end
    end

    // Either input may clear a lane
    assign hitMask = fresh[0] | fresh[1];

    // ----------------------------------------
    // Pressed flags
    // ----------------------------------------
    always_ff @(posedge Reset or posedge frame_clk) begin
        if (frame_clk) begin
            for (int k = 0; k < $size(keys); k++)
                pressed[k] <= '0;
        end else begin
            for (int k = 0; k < $size(keys); k++) begin
                if (match[k] != '0)
                    pressed[k] <= pressed[k] | match[k]; // Remember the lane until release
                else
                    pressed[k] <= '0;                    // Idle or other code frees this input
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/laneQueue.sv ====
// Holds at most two notes and assumes the second slot is valid only while the first one is valid
`default_nettype none
`timescale 1ns/1ps

module laneQueue (
    input  logic         Reset,            // Frame clock
    input  logic         frame_clk,        // Asynchronous reset, active high
    input  logic         spawn,            // New note request for this lane
    input  logic         hit,              // Lane key pressed
    output notePkg::posT firstY,           // Lowest note
    output notePkg::posT secondY,          // Note behind it
    output logic         firstValid,
    output logic         secondValid,
    output logic         miss              // First note fell past the bottom on the last edge
);
    import notePkg::*;

    posT  firstMoved;
    posT  secondMoved;
    logic missNow;
    logic pop;
    posT  firstNext;
    posT  secondNext;
    logic firstValidNext;
    logic secondValidNext;

    // Empty slots park at the spawn row
    assign firstMoved  = firstValid  ? posT'(firstY + NoteStep)  : SpawnY;
    assign secondMoved = secondValid ? posT'(secondY + NoteStep) : SpawnY;

    // Miss is judged on the position before this frame's step
    assign missNow = firstValid && (firstY >= MissY);
    assign pop     = hit || missNow;       // A hit and a miss together remove one note

    // ----------------------------------------
    // Move then pop then spawn
    // ----------------------------------------
    always_comb begin
        firstNext       = firstMoved;
        secondNext      = secondMoved;
        firstValidNext  = firstValid;
        secondValidNext = secondValid;

        if (pop) begin
            firstNext       = secondMoved; // Note behind moves up to the front
            firstValidNext  = secondValid;
            secondNext      = SpawnY;
            secondValidNext = 1'b0;
        end

        // New note takes the first free slot and is lost when both are full
        if (spawn) begin
            if (!firstValidNext) begin
                firstNext      = SpawnY;
                firstValidNext = 1'b1;
            end else if (!secondValidNext) begin
                secondNext      = SpawnY;
                secondValidNext = 1'b1;
            end
        end
    end

    always_ff @(posedge Reset or posedge frame_clk) begin
        if (frame_clk) begin
            firstY      <= SpawnY;
            secondY     <= SpawnY;
            firstValid  <= 1'b0;
            secondValid <= 1'b0;
            miss        <= 1'b0;
        end else begin
            firstY      <= firstNext;
            secondY     <= secondNext;
            firstValid  <= firstValidNext;
            secondValid <= secondValidNext;
            miss        <= missNow;        // Seen by the stamina register one edge later
        end
    end

endmodule

`default_nettype wire

// ==== source/noteField.sv ====
// Stamina drops one unit per frame with any miss and lags the miss pop by one frame
`default_nettype none
`timescale 1ns/1ps

module noteField (
    input  logic                          Reset,        // Frame clock
    input  logic                          frame_clk,    // Asynchronous reset, active high
    input  notePkg::laneCodeT             spawnCode0,
    input  notePkg::laneCodeT             spawnCode1,
    input  notePkg::keycodeT              keycode0,
    input  notePkg::keycodeT              keycode1,
    output notePkg::posT                  firstY  [notePkg::LaneCount],
    output notePkg::posT                  secondY [notePkg::LaneCount],
    output logic [2*notePkg::LaneCount-1:0] noteValid,  // Two bits per lane with the first slot low
    output notePkg::staminaT              stamina
);
    import notePkg::*;

    laneMaskT spawnMask;                   // Spawn pulses from the code decoder
    laneMaskT hitMask;                     // Hit pulses from the key decoder
    laneMaskT missMask;                    // Registered misses from the lanes

    // ----------------------------------------
    // Input decoders
    // ----------------------------------------
    spawnDecoder spawnDecoder_i (
        .Reset      (Reset),
        .frame_clk  (frame_clk),
        .spawnCode0 (spawnCode0),
        .spawnCode1 (spawnCode1),
        .spawnMask  (spawnMask)
    );

    keyDecoder keyDecoder_i (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .keycode0  (keycode0),
        .keycode1  (keycode1),
        .hitMask   (hitMask)
    );

    // ----------------------------------------
    // Lanes
    // ----------------------------------------
    for (genvar lane = 0; lane < LaneCount; lane++) begin : gLane
        laneQueue laneQueue_i (
            .Reset       (Reset),
            .frame_clk   (frame_clk),
            .spawn       (spawnMask[lane]),
            .hit         (hitMask[lane]),
            .firstY      (firstY[lane]),
            .secondY     (secondY[lane]),
            .firstValid  (noteValid[2*lane]),
            .secondValid (noteValid[2*lane+1]),
            .miss        (missMask[lane])
        );
    end

    // Several lanes missing in the same frame still cost a single unit
    always_ff @(posedge Reset or posedge frame_clk) begin
        if (frame_clk)
            stamina <= StaminaFull;
        else if (missMask != '0)
            stamina <= stamina >> 1;       // Top unit goes first
    end

endmodule

`default_nettype wire

// ==== testbench/noteFieldChecker.sv ====
// Model steps on the same edges as the DUT and compares on the falling edge where outputs are stable
`default_nettype none
`timescale 1ns/1ps

module noteFieldChecker (
    input logic                            Reset,       // Frame clock
    input logic                            frame_clk,   // Asynchronous reset, active high
    input notePkg::laneCodeT               spawnCode0,
    input notePkg::laneCodeT               spawnCode1,
    input notePkg::keycodeT                keycode0,
    input notePkg::keycodeT                keycode1,
    input notePkg::posT                    firstY  [notePkg::LaneCount],
    input notePkg::posT                    secondY [notePkg::LaneCount],
    input logic [2*notePkg::LaneCount-1:0] noteValid,
    input notePkg::staminaT                stamina
);
    import notePkg::*;

    int       errorCount = 0;              // Wrong values seen so far
    int       checkCount = 0;              // Compared values so far

    // ----------------------------------------
    // Model state
    // ----------------------------------------
    logic     armedM;                      // Spawn decoder ready for a new code
    laneMaskT pressedM [2];                // Held lane keys per keycode input
    posT      frontY   [LaneCount];        // Lowest note of each lane
    posT      backY    [LaneCount];        // Note behind it
    logic     frontOn  [LaneCount];
    logic     backOn   [LaneCount];
    logic     missM    [LaneCount];        // Miss registered on the last edge
    staminaT  staminaM;

    // Lane codes 1 to 5 name lanes 0 to 4 and all others name nothing
    function automatic laneMaskT codeToLane(input laneCodeT code);
        laneMaskT mask;
        mask = '0;
        if (code >= 3'd1 && code <= 3'd5)
            mask[code - 3'd1] = 1'b1;
        return mask;
    endfunction

    function automatic laneMaskT keyToLane(input keycodeT key);
        laneMaskT mask;
        mask = '0;
        for (int l = 0; l < LaneCount; l++)
            if (key == LaneKey[l])
                mask[l] = 1'b1;
        return mask;
    endfunction

    // ----------------------------------------
    // Model step in the order move, pop, spawn
    // ----------------------------------------
    always @(posedge Reset or posedge frame_clk) begin : stepModel
        laneMaskT spawnM;
        laneMaskT hitM;
        laneMaskT keyLanes;
        keycodeT  keys [2];
        logic     codeSeen;
        logic     anyMiss;
        logic     missNow;
        posT      frontFall;
        posT      backFall;
        if (frame_clk) begin
            armedM   = 1'b1;
            staminaM = StaminaFull;
            for (int k = 0; k < 2; k++)
                pressedM[k] = '0;
            for (int l = 0; l < LaneCount; l++) begin
                frontY[l]  = SpawnY;
                backY[l]   = SpawnY;
                frontOn[l] = 1'b0;
                backOn[l]  = 1'b0;
                missM[l]   = 1'b0;
            end
        end else begin
            codeSeen = (spawnCode0 != 3'd0) || (spawnCode1 != 3'd0);
            spawnM   = '0;
            if (armedM && codeSeen) begin
                spawnM = codeToLane(spawnCode0) | codeToLane(spawnCode1);
                armedM = 1'b0;                 // One shot until both codes go idle
            end else if (!codeSeen)
                armedM = 1'b1;

            keys[0] = keycode0;
            keys[1] = keycode1;
            hitM    = '0;
            for (int k = 0; k < 2; k++) begin
                keyLanes = keyToLane(keys[k]);
                hitM     = hitM | (keyLanes & ~pressedM[k]);
                // A non-lane code releases every flag of this input
                pressedM[k] = (keyLanes == '0) ? '0 : (pressedM[k] | keyLanes);
            end

            // Stamina follows the misses registered one edge earlier
            anyMiss = 1'b0;
            for (int l = 0; l < LaneCount; l++)
                anyMiss = anyMiss | missM[l];
            if (anyMiss)
                staminaM = staminaM >> 1;

            for (int l = 0; l < LaneCount; l++) begin
                missNow   = frontOn[l] && (frontY[l] >= MissY);
                frontFall = frontOn[l] ? posT'(frontY[l] + NoteStep) : SpawnY;
                backFall  = backOn[l]  ? posT'(backY[l] + NoteStep)  : SpawnY;
                if (hitM[l] || missNow) begin
                    frontY[l]  = backFall;     // Queue shifts forward by one note
                    frontOn[l] = backOn[l];
                    backY[l]   = SpawnY;
                    backOn[l]  = 1'b0;
                end else begin
                    frontY[l] = frontFall;
                    backY[l]  = backFall;
                end
                if (spawnM[l] && !frontOn[l]) begin
                    frontY[l]  = SpawnY;
                    frontOn[l] = 1'b1;
                end else if (spawnM[l] && !backOn[l]) begin
                    backY[l]  = SpawnY;
                    backOn[l] = 1'b1;
                end
                missM[l] = missNow;
            end
        end
    end

    task automatic checkValue(input string name, input logic [9:0] expected,
                              input logic [9:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("ERROR at %0d ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    // ----------------------------------------
    // Comparison of every output
    // ----------------------------------------
    always @(negedge Reset) begin : compareOutputs
        logic [2*LaneCount-1:0] validM;
        if (!frame_clk) begin                  // Model and DUT agree only once reset is out
            for (int l = 0; l < LaneCount; l++) begin
                validM[2*l]   = frontOn[l];    // First slot in the low bit
                validM[2*l+1] = backOn[l];
                checkValue($sformatf("firstY[%0d]", l), frontY[l], firstY[l]);
                checkValue($sformatf("secondY[%0d]", l), backY[l], secondY[l]);
            end
            checkValue("noteValid", validM, noteValid);
            checkValue("stamina", staminaM, stamina);
        end
    end

endmodule

`default_nettype wire

// ==== testbench/noteFieldTb.sv ====
// Runs directed sequences then 2000 random frames and stops on its own watchdog if the run stalls
`default_nettype none
`timescale 1ns/1ps

module noteFieldTb;
    import notePkg::*;

    localparam int ClockPeriod    = 4;     // ns
    localparam int ResetCycles    = 10;
    localparam int DirectedCycles = 250;   // Upper bound of the directed phase
    localparam int RandomCycles   = 2000;
    localparam int TotalCycles    = ResetCycles + DirectedCycles + RandomCycles;

    logic                   Reset;         // Frame clock
    logic                   frame_clk;     // Reset
    laneCodeT               spawnCode0;
    laneCodeT               spawnCode1;
    keycodeT                keycode0;
    keycodeT                keycode1;
    posT                    firstY  [LaneCount];
    posT                    secondY [LaneCount];
    logic [2*LaneCount-1:0] noteValid;
    staminaT                stamina;
    logic [31:0]            lcgState = 32'd81;

    noteField noteField_i (
        .Reset(Reset), .frame_clk(frame_clk),
        .spawnCode0(spawnCode0), .spawnCode1(spawnCode1),
        .keycode0(keycode0), .keycode1(keycode1),
        .firstY(firstY), .secondY(secondY), .noteValid(noteValid), .stamina(stamina)
    );

    noteFieldChecker noteFieldChecker_i (
        .Reset(Reset), .frame_clk(frame_clk),
        .spawnCode0(spawnCode0), .spawnCode1(spawnCode1),
        .keycode0(keycode0), .keycode1(keycode1),
        .firstY(firstY), .secondY(secondY), .noteValid(noteValid), .stamina(stamina)
    );

    initial begin
        Reset = 1'b0;
        forever #(ClockPeriod / 2) Reset = ~Reset;
    end

    // LCG with the usual 32-bit constants
    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    // Mostly idle or other codes so that notes live long enough to miss
    function automatic keycodeT pickKey(input logic [3:0] sel);
        if (sel < 4'd5)
            return LaneKey[sel[2:0]];
        else if (sel == 4'd5)
            return 8'h1A;
        else if (sel == 4'd6)
            return 8'h55;
        return 8'h00;
    endfunction

    // Holds one input set for a number of frames
    task automatic applyInputs(input laneCodeT c0, input laneCodeT c1,
                               input keycodeT k0, input keycodeT k1, input int cycles);
        repeat (cycles) begin
            @(posedge Reset);
            spawnCode0 <= c0;
            spawnCode1 <= c1;
            keycode0   <= k0;
            keycode1   <= k1;
        end
    endtask

    initial begin : watchdog
        #(2 * TotalCycles * ClockPeriod);
        $display("Timeout: the run did not end within %0d ns", 2 * TotalCycles * ClockPeriod);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] r2;
        frame_clk  = 1'b1;
        spawnCode0 = '0;
        spawnCode1 = '0;
        keycode0   = '0;
        keycode1   = '0;
        repeat (ResetCycles) @(posedge Reset);
        frame_clk <= 1'b0;

        // ----------------------------------------
        // Directed sequences
        // ----------------------------------------
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 3);      // Idle field after reset
        applyInputs(3'd1, 3'd0, 8'h00, 8'h00, 3);      // Held code spawns once
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd1, 3'd0, 8'h00, 8'h00, 1);      // Second slot of lane 0
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd0, 3'd1, 8'h00, 8'h00, 1);      // Full lane drops this one
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd2, 3'd2, 8'h00, 8'h00, 1);      // Equal codes give one note
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd6, 3'd7, 8'h00, 8'h00, 1);      // Out of range codes
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd4, 3'd5, 8'h00, 8'h00, 1);      // Lanes 3 and 4 will miss together
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd3, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd3, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd0, 3'd0, 8'h2C, 8'h00, 4);      // Held key pops once
        applyInputs(3'd0, 3'd0, 8'h2C, 8'h2C, 2);      // Other input pops on its own
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd3, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 1);
        applyInputs(3'd0, 3'd0, 8'h2C, 8'h00, 1);
        applyInputs(3'd3, 3'd0, 8'h55, 8'h00, 1);      // Non-lane code frees the flags as a note spawns
        applyInputs(3'd0, 3'd0, 8'h2C, 8'h00, 1);      // Press after release pops that note
        applyInputs(3'd0, 3'd0, 8'h00, 8'h07, 2);
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 170);    // Remaining notes fall past the line

        // ----------------------------------------
        // Random frames
        // ----------------------------------------
        for (int i = 0; i < RandomCycles; i++) begin
            r  = nextRandom();
            r2 = nextRandom();
            @(posedge Reset);
            if (r[31:30] == 2'b00) begin               // About a quarter of the frames
                spawnCode0 <= r[18:16];
                spawnCode1 <= r[21:19];
            end else begin
                spawnCode0 <= '0;
                spawnCode1 <= '0;
            end
            if (r2[31:27] == 5'd0)
                keycode0 <= pickKey(r2[3:0]);
            if (r2[26:22] == 5'd0)
                keycode1 <= pickKey(r2[7:4]);
        end
        applyInputs(3'd0, 3'd0, 8'h00, 8'h00, 5);
        @(posedge Reset);

        $display("Compared %0d values with %0d errors",
                 noteFieldChecker_i.checkCount, noteFieldChecker_i.errorCount);
        if (noteFieldChecker_i.checkCount == 0)
            $display("No DUT outputs were compared during the run");
        if (noteFieldChecker_i.errorCount == 0 && noteFieldChecker_i.checkCount != 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
source/notePkg.sv
source/spawnDecoder.sv
source/keyDecoder.sv
source/laneQueue.sv
source/noteField.sv
testbench/noteFieldChecker.sv
testbench/noteFieldTb.sv

// ==== Makefile ====
# Verilator build and run of the note field testbench
VERILATOR ?= verilator
TOP       ?= noteFieldTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides the result since tee hides the simulator status
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "=== PASS ===" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
